//--- include/mem_stage_defs.svh
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Data word and its byte lanes
`define WORD_WIDTH 32
`define BYTE_LANES 4		// Also the write-mask width

// Byte address seen by the memory stage
`define ADDR_BITS 16

//////////////////////////////////////////////////
// Local data memory
//////////////////////////////////////////////////

`define DMEM_WORDS 256
`define DMEM_ADDR_BITS 8	// Word index into local memory

// First byte address that goes out to the OCM
`define OCM_BASE (`DMEM_WORDS * `BYTE_LANES)

//////////////////////////////////////////////////
// Simulation budget
//////////////////////////////////////////////////

// Cycles allowed per test line before timeout
`define CYCLES_PER_TEST 40

`endif

//--- mem_stage.f
+incdir+include
verilog/mem_stage_pkg.sv
verilog/store_align.sv
verilog/load_extract.sv
verilog/shared_dmem.sv
verilog/ocm_atomic_unit.sv
verilog/mem_stage.sv
verif/mem_stage_checker.sv
verif/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mem_stage testbench with Verilator.
# Exits non-zero when the build fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f mem_stage.f --top-module mem_stage_tb -o sim_mem_stage > build.log 2>&1 \
	&& ./obj_dir/sim_mem_stage > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log \
	&& { echo "simulation reported failure"; exit 1; } \
	|| { echo "simulation finished clean"; exit 0; }

//--- verif/mem_stage_checker.sv
`timescale 1ns/1ns

module mem_stage_checker (
	input  logic                 clk,
	input  logic                 i_reset,
	// Test bookkeeping from the testbench
	input  logic                 i_test_end,		// Judge the current test
	input  logic [1:0]           i_mode,			// What result to expect
	input  logic [127:0]         i_test_name,
	input  mem_stage_pkg::word_t i_exp_data,
	input  logic                 i_expect_done,
	input  logic                 i_expect_stall,
	input  logic                 i_finish,
	// Watched DUT ports
	input  logic                 i_stall,
	input  logic                 i_load_valid,
	input  mem_stage_pkg::word_t i_load_data,
	input  mem_stage_pkg::word_t i_con_out,
	input  logic                 i_request,
	input  logic                 i_grant,
	input  logic                 i_ocm_done,
	output int                   o_pass_count,
	output int                   o_fail_count
);
	import mem_stage_pkg::*;

	localparam logic [1:0] MODE_LOAD = 2'd1;
	localparam logic [1:0] MODE_CON = 2'd2;

	logic seen = 1'b0;		// Load pulse in this test
	word_t got = '0;
	int done_cnt = 0;
	int stall_cnt = 0;
	int pending_err = 0;	// Protocol errors since last test
	logic prev_reset = 1'b1;
	logic req_q = 1'b0;
	logic gnt_q = 1'b0;
	logic reported = 1'b0;

	initial begin
		o_pass_count = 0;
		o_fail_count = 0;
	end

	//////////////////////////////////////////////////
	// Per-test verdict
	//////////////////////////////////////////////////

	task automatic judge_test();
		int errs;
		errs = pending_err;
		pending_err = 0;
		if (i_mode == MODE_LOAD) begin
			if (!seen) begin
				$display("%0s: no load result pulse", i_test_name);
				errs++;
			end else if (got !== i_exp_data) begin
				$display("mismatch %0s expected %h actual %h", i_test_name,
					i_exp_data, got);
				errs++;
			end
		end else if (i_mode == MODE_CON) begin
			if (i_con_out !== i_exp_data) begin
				$display("mismatch %0s expected %h actual %h", i_test_name,
					i_exp_data, i_con_out);
				errs++;
			end
		end else if (seen) begin
			$display("%0s: load result pulse after an operation without one", i_test_name);
			errs++;
		end
		if (done_cnt != (i_expect_done ? 1 : 0)) begin
			$display("%0s: %0d OCM done pulses, expected %0d", i_test_name, done_cnt,
				i_expect_done ? 1 : 0);
			errs++;
		end
		if (i_expect_stall && stall_cnt == 0) begin
			$display("%0s: no stall on a port collision", i_test_name);
			errs++;
		end
		if (errs == 0) begin
			$display("test %0s ok", i_test_name);
			o_pass_count++;
		end else begin
			$display("test %0s failed with %0d errors", i_test_name, errs);
			o_fail_count++;
		end
		seen = 1'b0;	// Fresh start for the next test
		done_cnt = 0;
		stall_cnt = 0;
	endtask

	//////////////////////////////////////////////////
	// Port watcher
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (i_reset) begin
			prev_reset = 1'b1;
			req_q = 1'b0;
			gnt_q = 1'b0;
		end else begin
			// Outputs must be idle in the first cycle out of reset
			if (prev_reset && (i_stall || i_request || i_ocm_done || i_load_valid)) begin
				$display("DUT outputs were not idle right after reset");
				pending_err++;
			end
			prev_reset = 1'b0;
			if (req_q && !gnt_q && !i_request) begin
				$display("OCM request dropped before it was granted");
				pending_err++;
			end
			req_q = i_request;
			gnt_q = i_grant;
			if (i_load_valid) begin
				seen = 1'b1;
				got = i_load_data;
			end
			if (i_ocm_done)
				done_cnt++;
			if (i_stall)
				stall_cnt++;
			if (i_test_end)
				judge_test();
			if (i_finish && !reported) begin
				$display("%0d tests: %0d passed, %0d failed", o_pass_count + o_fail_count,
					o_pass_count, o_fail_count);
				reported = 1'b1;
			end
		end
	end

endmodule

//--- verif/mem_stage_tb.sv
`timescale 1ns/1ns

`include "mem_stage_defs.svh"

module mem_stage_tb;
	import mem_stage_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int MAX_TESTS = 64;

	logic clk;
	logic i_reset;
	logic i_op_valid, i_op_load, i_op_store, i_is_atomic;
	atomic_op_t i_atomic_op;
	addr_t i_addr;
	word_t i_store_data;
	store_select_t i_store_select;
	dm_select_t i_dm_select;
	logic i_con_en;
	byte_mask_t i_con_write;
	logic [`DMEM_ADDR_BITS-1:0] i_con_addr;
	word_t i_con_in, o_con_out;
	logic o_request, o_ocm_done, i_grant, o_stall, o_load_valid;
	addr_t o_ocm_addr;
	byte_mask_t o_ocm_dm_write;
	word_t o_ocm_data, i_ocm_data, o_load_data;

	// Checker handshake
	logic test_end, expect_done, expect_stall, finish;
	logic [1:0] mode;
	logic [127:0] test_name;
	word_t exp_data;
	int pass_count, fail_count;

	// Test table from the file
	logic [127:0] names [MAX_TESTS];
	logic [127:0] kinds [MAX_TESTS];
	logic [31:0] addrs [MAX_TESTS], sizes [MAX_TESTS], datas [MAX_TESTS], exps [MAX_TESTS];
	int ntests = 0;
	int limit = 0;
	int cycles = 0;
	integer fd;
	integer seed;
	int gnt_cnt;
	word_t ocm_mem [1 << (`ADDR_BITS - 2)];	// OCM responder words

	mem_stage i_mem_stage (.*);

	mem_stage_checker i_checker (
		.clk (clk), .i_reset (i_reset), .i_test_end (test_end), .i_mode (mode),
		.i_test_name (test_name), .i_exp_data (exp_data), .i_expect_done (expect_done),
		.i_expect_stall (expect_stall), .i_finish (finish), .i_stall (o_stall),
		.i_load_valid (o_load_valid), .i_load_data (o_load_data), .i_con_out (o_con_out),
		.i_request (o_request), .i_grant (i_grant), .i_ocm_done (o_ocm_done),
		.o_pass_count (pass_count), .o_fail_count (fail_count)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;	// 10 ns period

	//////////////////////////////////////////////////
	// OCM responder with random grant delay
	//////////////////////////////////////////////////

	initial begin
		seed = 32'hf38d_c137;
		for (int i = 0; i < (1 << (`ADDR_BITS - 2)); i++)
			ocm_mem[i] = 32'h5a5a_0000 ^ i;	// Whole word address in the fill
	end

	always @(posedge clk) begin
		int d;
		if (i_reset) begin
			i_grant <= 1'b0;
			gnt_cnt <= -1;
		end else if (i_grant) begin
			i_grant <= 1'b0;	// Address and mask are valid in the grant cycle
			for (int l = 0; l < `BYTE_LANES; l++)
				if (o_ocm_dm_write[l])
					ocm_mem[o_ocm_addr[15:2]][l*8 +: 8] <= o_ocm_data[l*8 +: 8];
			i_ocm_data <= ocm_mem[o_ocm_addr[15:2]];	// Old word next cycle
		end else if (o_request) begin
			if (gnt_cnt < 0)
				d = ($random(seed) & 32'h7fff_ffff) % 6;
			else
				d = gnt_cnt;
			if (d == 0) begin
				i_grant <= 1'b1;
				gnt_cnt <= -1;
			end else begin
				gnt_cnt <= d - 1;
			end
		end
	end

	// Cycle budget
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Test file and stimulus
	//////////////////////////////////////////////////

	task automatic read_tests();
		logic [127:0] tok;
		logic [8*160-1:0] rest;
		int code;
		logic stop;
		stop = 1'b0;
		while (!stop && ntests < MAX_TESTS) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				stop = 1'b1;
			end else if (tok == "#") begin
				code = $fgets(rest, fd);	// Skip comment text
			end else begin
				names[ntests] = tok;
				code = $fscanf(fd, "%s %h %h %h %h", kinds[ntests], addrs[ntests],
					sizes[ntests], datas[ntests], exps[ntests]);
				ntests++;
			end
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int i);
		logic core_op;
		core_op = kinds[i] == "load" || kinds[i] == "store" || kinds[i] == "atomic"
			|| kinds[i] == "collide";
		@(posedge clk);
		test_name <= names[i];
		exp_data <= exps[i];
		expect_stall <= kinds[i] == "collide";
		expect_done <= core_op && (kinds[i] == "atomic" || addrs[i] >= `OCM_BASE);
		if (kinds[i] == "conrd")
			mode <= 2'd2;
		else if (kinds[i] == "load" || kinds[i] == "atomic" || kinds[i] == "collide")
			mode <= 2'd1;
		else
			mode <= 2'd0;
		if (core_op) begin
			i_op_valid <= 1'b1;
			i_op_load <= kinds[i] == "load" || kinds[i] == "collide";
			i_op_store <= kinds[i] == "store";
			i_is_atomic <= kinds[i] == "atomic";
			i_atomic_op <= atomic_op_t'(sizes[i][2:0]);
			i_addr <= addrs[i][15:0];
			i_store_data <= datas[i];
			i_store_select <= store_select_t'(sizes[i][1:0]);
			i_dm_select <= dm_select_t'(sizes[i][2:0]);
			if (kinds[i] == "collide") begin
				i_con_en <= 1'b1;	// Con read of word 0 in the same cycle
				i_con_write <= '0;
				i_con_addr <= '0;
			end
			do begin
				@(posedge clk);
				i_con_en <= 1'b0;
			end while (o_stall);	// Held until accepted
			i_op_valid <= 1'b0;
		end else begin
			i_con_en <= 1'b1;
			i_con_write <= kinds[i] == "conwr" ? byte_mask_t'(sizes[i][3:0]) : '0;
			i_con_addr <= addrs[i][7:0];
			i_con_in <= datas[i];
			@(posedge clk);
			i_con_en <= 1'b0;
			i_con_write <= '0;
		end
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	initial begin
		i_reset = 1'b1;
		i_op_valid = 1'b0;
		i_op_load = 1'b0;
		i_op_store = 1'b0;
		i_is_atomic = 1'b0;
		i_atomic_op = AMO_SWAP;
		i_addr = '0;
		i_store_data = '0;
		i_store_select = ST_WORD;
		i_dm_select = DM_WORD;
		i_con_en = 1'b0;
		i_con_write = '0;
		i_con_addr = '0;
		i_con_in = '0;
		i_grant = 1'b0;
		i_ocm_data = '0;
		test_end = 1'b0;
		expect_done = 1'b0;
		expect_stall = 1'b0;
		finish = 1'b0;
		mode = 2'd0;
		test_name = '0;
		exp_data = '0;
		fd = $fopen("verif/mem_stage_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/mem_stage_tests.txt");
			$display("RESULT: FAIL");
			$finish;
		end else begin
			read_tests();
			limit = ntests * `CYCLES_PER_TEST + RESET_CYCLES;
			repeat (RESET_CYCLES) @(posedge clk);
			i_reset <= 1'b0;
			@(posedge clk);
			for (int i = 0; i < ntests; i++)
				run_test(i);
			finish <= 1'b1;	// Checker prints its counts
			repeat (3) @(posedge clk);
			if (ntests > 0 && fail_count == 0 && pass_count == ntests)
				$display("RESULT: PASS");
			else
				$display("RESULT: FAIL");
			$finish;
		end
	end

endmodule

//--- verif/mem_stage_tests.txt
# name kind addr(hex) size(hex: load type, store size, atomic op or con mask) data(hex) expected(hex)
# kinds: load store atomic conwr conrd collide
st_w0 store 0010 2 12345678 0
ld_w0 load 0010 2 0 12345678
st_b1 store 0011 0 000000aa 0
ld_w1 load 0010 2 0 1234aa78
ld_b1 load 0011 0 0 ffffffaa
ld_bu1 load 0011 3 0 000000aa
st_b3 store 0013 0 0000007f 0
ld_b3 load 0013 0 0 0000007f
st_b0 store 0010 0 00000080 0
ld_b0 load 0010 0 0 ffffff80
st_h2 store 0012 1 00008001 0
ld_h2 load 0012 1 0 ffff8001
ld_hu2 load 0012 4 0 00008001
st_h0 store 0010 1 00001234 0
ld_h0 load 0010 1 0 00001234
ld_w2 load 0010 2 0 80011234
ld_bu2 load 0012 3 0 00000001
cw_5 conwr 0005 f cafef00d 0
ld_cw load 0014 2 0 cafef00d
cw_5m conwr 0005 3 00001111 0
ld_cwm load 0014 2 0 cafe1111
st_w6 store 0018 2 deadbeef 0
cr_6 conrd 0006 0 0 deadbeef
col_ld collide 0014 2 0 cafe1111
ol_fill load 0408 2 0 5a5a0102
os_w store 0400 2 0badf00d 0
ol_w load 0400 2 0 0badf00d
os_b store 0402 0 00000055 0
ol_b load 0402 0 0 00000055
ol_w2 load 0400 2 0 0b55f00d
ol_hu load 0402 4 0 00000b55
os_a store 0404 2 0000000f 0
am_add atomic 0404 1 00000001 0000000f
ol_add load 0404 2 0 00000010
am_and atomic 0404 2 00000030 00000010
am_or atomic 0404 3 00000f00 00000010
am_xor atomic 0404 4 0000ffff 00000f10
ol_xor load 0404 2 0 0000f0ef
am_swap atomic 0404 0 12345678 0000f0ef
ol_swp load 0404 2 0 12345678

//--- verilog/load_extract.sv
`timescale 1ns/1ns

module load_extract (
	input  mem_stage_pkg::word_t      i_data,			// Raw memory word
	input  logic [1:0]                i_byte_offset,	// Low address bits
	input  mem_stage_pkg::dm_select_t i_dm_select,		// Load type
	output mem_stage_pkg::word_t      o_load_data		// Extended result
);
	import mem_stage_pkg::*;

	logic [7:0] byte_field;
	logic [15:0] half_field;

	//////////////////////////////////////////////////
	// Field select
	//////////////////////////////////////////////////

	// Byte at offset*8
	assign byte_field = i_data[{i_byte_offset, 3'b000} +: 8];

	// Halfword picked by bit 1 only
	assign half_field = i_byte_offset[1] ? i_data[31:16] : i_data[15:0];

	//////////////////////////////////////////////////
	// Extension
	//////////////////////////////////////////////////

	always_comb begin
		case (i_dm_select)
			DM_BYTE: begin
				o_load_data = {{24{byte_field[7]}}, byte_field};	// Sign extend
			end
			DM_BYTEU: begin
				o_load_data = {24'd0, byte_field};
			end
			DM_HALF: begin
				o_load_data = {{16{half_field[15]}}, half_field};	// Sign extend
			end
			DM_HALFU: begin
				o_load_data = {16'd0, half_field};
			end
			default: begin
				o_load_data = i_data;	// lw passes through
			end
		endcase
	end

endmodule

//--- verilog/mem_stage.sv
`timescale 1ns/1ns

`include "mem_stage_defs.svh"

module mem_stage (
	input  logic                          clk,
	input  logic                          i_reset,

	// Core operation held while stalled
	input  logic                          i_op_valid,
	input  logic                          i_op_load,
	input  logic                          i_op_store,
	input  logic                          i_is_atomic,
	input  mem_stage_pkg::atomic_op_t     i_atomic_op,
	input  mem_stage_pkg::addr_t          i_addr,
	input  mem_stage_pkg::word_t          i_store_data,
	input  mem_stage_pkg::store_select_t  i_store_select,
	input  mem_stage_pkg::dm_select_t     i_dm_select,

	// Protocol controller port
	input  logic                          i_con_en,
	input  mem_stage_pkg::byte_mask_t     i_con_write,
	input  logic [`DMEM_ADDR_BITS-1:0]    i_con_addr,
	input  mem_stage_pkg::word_t          i_con_in,
	output mem_stage_pkg::word_t          o_con_out,

	// OCM request/grant
	output logic                          o_request,
	output mem_stage_pkg::addr_t          o_ocm_addr,
	output mem_stage_pkg::byte_mask_t     o_ocm_dm_write,
	output mem_stage_pkg::word_t          o_ocm_data,
	output logic                          o_ocm_done,
	input  logic                          i_grant,
	input  mem_stage_pkg::word_t          i_ocm_data,

	// Results
	output logic                          o_stall,
	output mem_stage_pkg::word_t          o_load_data,
	output logic                          o_load_valid
);
	import mem_stage_pkg::*;

	logic to_ocm;
	logic local_op;
	logic ocm_op;
	logic ocm_start;
	logic ocm_active;		// Sequence in flight
	logic core_grant;
	word_t aligned_data;
	byte_mask_t aligned_mask;
	word_t dmem_data;
	word_t ocm_old;
	word_t ret_word;
	word_t extracted;
	logic load_pend_q;		// Local load result next cycle
	logic [1:0] off_q;
	dm_select_t sel_q;

	//////////////////////////////////////////////////
	// Routing
	//////////////////////////////////////////////////

	// Atomics need the RMW unit so always go out
	assign to_ocm = i_is_atomic || (i_addr >= addr_t'(`OCM_BASE));
	assign local_op = i_op_valid && !to_ocm && (i_op_load || i_op_store);
	assign ocm_op = i_op_valid && to_ocm && (i_op_load || i_op_store || i_is_atomic);
	assign ocm_start = ocm_op && !ocm_active;	// First stalled cycle only

	store_align i_store_align (
		.i_store_data   (i_store_data),
		.i_byte_offset  (i_addr[1:0]),
		.i_store_select (i_store_select),
		.i_is_store     (i_op_store && !i_is_atomic),
		.o_data         (aligned_data),
		.o_dm_write     (aligned_mask)
	);

	shared_dmem i_shared_dmem (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_core_en    (local_op),
		.i_core_write (aligned_mask),
		.i_core_addr  (i_addr[`DMEM_ADDR_BITS+1:2]),	// Word index
		.i_core_data  (aligned_data),
		.i_con_en     (i_con_en),
		.i_con_write  (i_con_write),
		.i_con_addr   (i_con_addr),
		.i_con_in     (i_con_in),
		.o_core_grant (core_grant),
		.o_core_data  (dmem_data),
		.o_con_out    (o_con_out)
	);

	ocm_atomic_unit i_ocm_atomic_unit (
		.clk            (clk),
		.i_reset        (i_reset),
		.i_start        (ocm_start),
		.i_is_load      (i_op_load),
		.i_is_atomic    (i_is_atomic),
		.i_atomic_op    (i_atomic_op),
		.i_addr         (i_addr),
		.i_dm_write     (aligned_mask),
		.i_data         (i_is_atomic ? i_store_data : aligned_data),	// Raw AMO operand
		.i_grant        (i_grant),
		.i_ocm_data     (i_ocm_data),
		.o_request      (o_request),
		.o_ocm_addr     (o_ocm_addr),
		.o_ocm_dm_write (o_ocm_dm_write),
		.o_ocm_data     (o_ocm_data),
		.o_done         (o_ocm_done),
		.o_old_data     (ocm_old)
	);

	// Lost arbitration or OCM still busy
	assign o_stall = (local_op && !core_grant) || (ocm_op && !o_ocm_done);

	//////////////////////////////////////////////////
	// Local return bookkeeping
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_reset) begin
			load_pend_q <= 1'b0;
			ocm_active <= 1'b0;
		end else begin
			load_pend_q <= local_op && core_grant && i_op_load;
			if (ocm_start)
				ocm_active <= 1'b1;
			else if (o_ocm_done)
				ocm_active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		off_q <= i_addr[1:0];
		sel_q <= i_dm_select;
	end

	// OCM fields are still held in the done cycle
	assign ret_word = o_ocm_done ? ocm_old : dmem_data;

	load_extract i_load_extract (
		.i_data        (ret_word),
		.i_byte_offset (o_ocm_done ? i_addr[1:0] : off_q),
		.i_dm_select   (o_ocm_done ? i_dm_select : sel_q),
		.o_load_data   (extracted)
	);

	assign o_load_data = (o_ocm_done && i_is_atomic) ? ocm_old : extracted;	// AMO old word raw
	assign o_load_valid = load_pend_q || (o_ocm_done && (i_op_load || i_is_atomic));

	// Source keeps a stalled operation steady
	assert property (@(posedge clk) disable iff (i_reset)
			(i_op_valid && o_stall) |=> (i_op_valid && $stable(i_addr)
			&& $stable(i_op_load) && $stable(i_is_atomic) && $stable(i_dm_select)))
		else $error("mem_stage: operation changed while stalled");

endmodule

//--- verilog/mem_stage_pkg.sv
`include "mem_stage_defs.svh"

package mem_stage_pkg;

	// Basic datapath types
	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`BYTE_LANES-1:0] byte_mask_t;	// One bit per byte lane
	typedef logic [`ADDR_BITS-1:0] addr_t;			// Byte address

	// Load type, picks field and extension
	typedef enum logic [2:0] {
		DM_BYTE  = 3'd0,	// lb
		DM_HALF  = 3'd1,	// lh
		DM_WORD  = 3'd2,	// lw
		DM_BYTEU = 3'd3,	// lbu
		DM_HALFU = 3'd4		// lhu
	} dm_select_t;

	// Store size
	typedef enum logic [1:0] {
		ST_BYTE = 2'd0,
		ST_HALF = 2'd1,
		ST_WORD = 2'd2
	} store_select_t;

	// Read-modify-write ops done by the OCM unit
	typedef enum logic [2:0] {
		AMO_SWAP = 3'd0,
		AMO_ADD  = 3'd1,
		AMO_AND  = 3'd2,
		AMO_OR   = 3'd3,
		AMO_XOR  = 3'd4
	} atomic_op_t;

endpackage

//--- verilog/ocm_atomic_unit.sv
`timescale 1ns/1ns

module ocm_atomic_unit (
	input  logic                      clk,
	input  logic                      i_reset,
	input  logic                      i_start,		// One cycle, unit idle
	input  logic                      i_is_load,
	input  logic                      i_is_atomic,
	input  mem_stage_pkg::atomic_op_t i_atomic_op,
	input  mem_stage_pkg::addr_t      i_addr,
	input  mem_stage_pkg::byte_mask_t i_dm_write,
	input  mem_stage_pkg::word_t      i_data,		// Store data or AMO operand
	input  logic                      i_grant,
	input  mem_stage_pkg::word_t      i_ocm_data,	// Valid the cycle after grant
	output logic                      o_request,
	output mem_stage_pkg::addr_t      o_ocm_addr,
	output mem_stage_pkg::byte_mask_t o_ocm_dm_write,
	output mem_stage_pkg::word_t      o_ocm_data,
	output logic                      o_done,		// End of sequence pulse
	output mem_stage_pkg::word_t      o_old_data	// Word read from the OCM
);
	import mem_stage_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE    = 2'd0,
		S_REQ     = 2'd1,	// First access, read or write
		S_RD_WAIT = 2'd2,	// Read data arrives
		S_WR_REQ  = 2'd3	// AMO write-back
	} state_t;

	state_t state;
	logic done_q;
	logic is_load_q;
	logic is_atomic_q;
	atomic_op_t op_q;
	addr_t addr_q;
	byte_mask_t mask_q;
	word_t data_q;
	word_t old_q;
	word_t amo_result;

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= S_IDLE;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;	// Pulse by default low
			case (state)
				S_IDLE: begin
					if (i_start)
						state <= S_REQ;
				end
				S_REQ: begin
					if (i_grant) begin
						if (is_load_q || is_atomic_q) begin
							state <= S_RD_WAIT;
						end else begin
							state <= S_IDLE;	// Plain store finished
							done_q <= 1'b1;
						end
					end
				end
				S_RD_WAIT: begin
					if (is_atomic_q) begin
						state <= S_WR_REQ;	// Second access
					end else begin
						state <= S_IDLE;
						done_q <= 1'b1;
					end
				end
				default: begin
					if (i_grant) begin
						state <= S_IDLE;
						done_q <= 1'b1;
					end
				end
			endcase
		end
	end

	// AMO ALU, memory word against operand
	always_comb begin
		case (op_q)
			AMO_ADD: amo_result = i_ocm_data + data_q;
			AMO_AND: amo_result = i_ocm_data & data_q;
			AMO_OR:  amo_result = i_ocm_data | data_q;
			AMO_XOR: amo_result = i_ocm_data ^ data_q;
			default: amo_result = data_q;	// Swap
		endcase
	end

	// Operation capture and read data
	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_start) begin
			is_load_q <= i_is_load;
			is_atomic_q <= i_is_atomic;
			op_q <= i_atomic_op;
			addr_q <= i_addr;
			mask_q <= i_dm_write;
			data_q <= i_data;
		end
		if (state == S_RD_WAIT) begin
			old_q <= i_ocm_data;
			if (is_atomic_q)
				data_q <= amo_result;	// Value for write-back
		end
	end

	//////////////////////////////////////////////////
	// OCM outputs
	//////////////////////////////////////////////////

	assign o_request = (state == S_REQ) || (state == S_WR_REQ);

	always_comb begin
		case (state)
			S_REQ:    o_ocm_dm_write = (is_load_q || is_atomic_q) ? '0 : mask_q;
			S_WR_REQ: o_ocm_dm_write = '1;	// AMOs are full word
			default:  o_ocm_dm_write = '0;
		endcase
	end

	assign o_ocm_addr = addr_q;
	assign o_ocm_data = data_q;
	assign o_done = done_q;
	assign o_old_data = old_q;

	// Request is a level held until granted
	assert property (@(posedge clk) disable iff (i_reset)
			(o_request && !i_grant) |=> o_request)
		else $error("ocm_atomic_unit: request dropped without grant");

endmodule

//--- verilog/shared_dmem.sv
`timescale 1ns/1ns

`include "mem_stage_defs.svh"

module shared_dmem (
	input  logic                        clk,
	input  logic                        i_reset,

	// Core side loses to the con port
	input  logic                        i_core_en,
	input  mem_stage_pkg::byte_mask_t   i_core_write,
	input  logic [`DMEM_ADDR_BITS-1:0]  i_core_addr,	// Word index
	input  mem_stage_pkg::word_t        i_core_data,

	// Protocol controller side is always served
	input  logic                        i_con_en,
	input  mem_stage_pkg::byte_mask_t   i_con_write,
	input  logic [`DMEM_ADDR_BITS-1:0]  i_con_addr,
	input  mem_stage_pkg::word_t        i_con_in,

	output logic                        o_core_grant,
	output mem_stage_pkg::word_t        o_core_data,	// Registered read
	output mem_stage_pkg::word_t        o_con_out		// Registered read
);
	import mem_stage_pkg::*;

	word_t mem [`DMEM_WORDS];

	// Fixed priority with the con port first
	assign o_core_grant = i_core_en && !i_con_en;

	// Lane-masked write from whichever side owns the cycle
	always_ff @(posedge clk) begin
		for (int lane = 0; lane < `BYTE_LANES; lane++) begin
			if (i_con_en) begin
				if (i_con_write[lane])
					mem[i_con_addr][lane*8 +: 8] <= i_con_in[lane*8 +: 8];
			end else if (o_core_grant && i_core_write[lane]) begin
				mem[i_core_addr][lane*8 +: 8] <= i_core_data[lane*8 +: 8];
			end
		end
	end

	// Read ports return the old word on a same-cycle write
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_core_data <= '0;
			o_con_out <= '0;
		end else begin
			if (i_con_en)
				o_con_out <= mem[i_con_addr];	// Held until next con access
			if (o_core_grant)
				o_core_data <= mem[i_core_addr];
		end
	end

	// Core write in a con cycle must leave its word untouched
	assert property (@(posedge clk) disable iff (i_reset)
			(i_con_en && i_core_en && (|i_core_write) && (i_core_addr != i_con_addr))
			|=> (mem[$past(i_core_addr)] === $past(mem[i_core_addr])))
		else $error("shared_dmem: core write reached memory in a con cycle");

endmodule

//--- verilog/store_align.sv
`timescale 1ns/1ns

module store_align (
	input  mem_stage_pkg::word_t         i_store_data,	// Unaligned register value
	input  logic [1:0]                   i_byte_offset,	// Low address bits
	input  mem_stage_pkg::store_select_t i_store_select,
	input  logic                         i_is_store,
	output mem_stage_pkg::word_t         o_data,		// Lane-replicated data
	output mem_stage_pkg::byte_mask_t    o_dm_write		// Byte-write enables
);
	import mem_stage_pkg::*;

	byte_mask_t lane_mask;	// Mask before the store qualifier

	// Replicate the field so every lane sees it
	always_comb begin
		case (i_store_select)
			ST_BYTE: begin
				o_data = {4{i_store_data[7:0]}};
				lane_mask = byte_mask_t'(4'b0001 << i_byte_offset);
			end
			ST_HALF: begin
				o_data = {2{i_store_data[15:0]}};
				lane_mask = i_byte_offset[1] ? 4'b1100 : 4'b0011;	// Upper or lower half
			end
			default: begin
				o_data = i_store_data;	// Full word
				lane_mask = 4'b1111;
			end
		endcase
	end

	assign o_dm_write = i_is_store ? lane_mask : '0;	// Loads never write

	// Halfword stores only start on an even byte
	always_comb begin
		if (i_is_store && i_store_select == ST_HALF)
			assert (!i_byte_offset[0])
				else $error("store_align: halfword store at odd offset %0d", i_byte_offset);
	end

endmodule
